/* logic/tetris_pkg.sv */
package tetris_pkg;

        ////////////////////////////////////////////////////////////////////
        // board geometry
        ////////////////////////////////////////////////////////////////////

        localparam int board_cols   = 10;
        localparam int board_rows_n = 20;
        localparam int cell_px      = 20;      // pixels per cell edge

        ////////////////////////////////////////////////////////////////////
        // types
        ////////////////////////////////////////////////////////////////////

        typedef logic [9:0] coord_t;            // pixel coordinate
        typedef logic [board_cols-1:0] row_t;   // bit k is column k
        typedef logic [4:0] row_idx_t;          // row 0 at the top

        // one top height per column
        typedef coord_t [board_cols-1:0] col_tops_t;

        typedef logic [7:0] lines_t;            // wraps

        typedef enum logic [1:0] {
                st_idle,
                st_place,
                st_scan,
                st_clear
        } lock_state_t;

endpackage

/* logic/lock_fsm.sv */
`timescale 1ns/1ns

module lock_fsm (
        input  logic Clk,
        input  logic arst_n,
        input  logic at_bottom,
        input  logic row_full,
        input  logic scan_last,
        output logic busy,
        output logic place,
        output logic clear_row,
        output logic cnt_load,
        output logic cnt_step
);
        import tetris_pkg::*;

        lock_state_t state;
        lock_state_t state_nxt;

        always_ff @(posedge Clk or negedge arst_n) begin
                if (!arst_n) begin
                        state <= st_idle;
                end else begin
                        state <= state_nxt;
                end
        end

        ////////////////////////////////////////////////////////////////////
        // next state and step controls
        ////////////////////////////////////////////////////////////////////

        always_comb begin
                state_nxt = state;
                place     = 1'b0;
                clear_row = 1'b0;
                cnt_load  = 1'b0;
                cnt_step  = 1'b0;

                case (state)
                st_idle: begin
                        if (at_bottom) begin
                                state_nxt = st_place;
                        end
                end
                st_place: begin
                        place     = 1'b1;
                        cnt_load  = 1'b1;       // start at bottom row
                        state_nxt = st_scan;
                end
                st_scan: begin
                        if (row_full) begin
                                state_nxt = st_clear;
                        end else if (scan_last) begin
                                state_nxt = st_idle;
                        end else begin
                                cnt_step = 1'b1;
                        end
                end
                st_clear: begin
                        // rows above drop into this one, so rescan it
                        clear_row = 1'b1;
                        state_nxt = st_scan;
                end
                default: state_nxt = st_idle;
                endcase
        end

        assign busy = (state != st_idle);

endmodule

/* logic/row_scan_counter.sv */
`timescale 1ns/1ns

module row_scan_counter (
        input  logic Clk,
        input  logic arst_n,
        input  logic cnt_load,
        input  logic cnt_step,
        output tetris_pkg::row_idx_t scan_row,
        output logic scan_last
);
        import tetris_pkg::*;

        localparam row_idx_t bottom_row = row_idx_t'(board_rows_n - 1);

        // walks upward, bottom row first
        always_ff @(posedge Clk or negedge arst_n) begin
                if (!arst_n) begin
                        scan_row <= '0;
                end else if (cnt_load) begin
                        scan_row <= bottom_row;
                end else if (cnt_step) begin
                        scan_row <= scan_row - 1'b1;
                end
        end

        assign scan_last = (scan_row == '0);    // top row reached

endmodule

/* logic/board_rows.sv */
`timescale 1ns/1ns

module board_rows (
        input  logic Clk,
        input  logic arst_n,
        input  logic at_bottom,
        input  tetris_pkg::coord_t square1x,
        input  tetris_pkg::coord_t square1y,
        input  tetris_pkg::coord_t square2x,
        input  tetris_pkg::coord_t square2y,
        input  tetris_pkg::coord_t square3x,
        input  tetris_pkg::coord_t square3y,
        input  tetris_pkg::coord_t square4x,
        input  tetris_pkg::coord_t square4y,
        input  logic place,
        input  logic clear_row,
        input  tetris_pkg::row_idx_t scan_row,
        output logic row_full,
        output tetris_pkg::row_t [tetris_pkg::board_rows_n-1:0] grid,
        output tetris_pkg::lines_t lines_cleared
);
        import tetris_pkg::*;

        localparam coord_t x_limit = coord_t'(board_cols * cell_px);
        localparam coord_t y_limit = coord_t'(board_rows_n * cell_px);

        coord_t sq_x [4];
        coord_t sq_y [4];

        // latched piece cells
        logic [$clog2(board_cols)-1:0] cell_col [4];
        row_idx_t cell_row [4];
        logic cell_ok [4];

        always_comb begin
                sq_x[0] = square1x;
                sq_y[0] = square1y;
                sq_x[1] = square2x;
                sq_y[1] = square2y;
                sq_x[2] = square3x;
                sq_y[2] = square3y;
                sq_x[3] = square4x;
                sq_y[3] = square4y;
        end

        ////////////////////////////////////////////////////////////////////
        // capture on at_bottom
        ////////////////////////////////////////////////////////////////////

        always_ff @(posedge Clk) begin
                if (at_bottom) begin
                        for (int k = 0; k < 4; k++) begin
                                // off-board squares never get written
                                cell_ok[k]  <= (sq_x[k] < x_limit) && (sq_y[k] < y_limit);
                                cell_col[k] <= ($clog2(board_cols))'(sq_x[k] / coord_t'(cell_px));
                                cell_row[k] <= row_idx_t'(sq_y[k] / coord_t'(cell_px));
                        end
                end
        end

        ////////////////////////////////////////////////////////////////////
        // grid update
        ////////////////////////////////////////////////////////////////////

        always_ff @(posedge Clk or negedge arst_n) begin
                if (!arst_n) begin
                        grid          <= '0;
                        lines_cleared <= '0;
                end else if (place) begin
                        for (int k = 0; k < 4; k++) begin
                                if (cell_ok[k]) begin
                                        grid[cell_row[k]][cell_col[k]] <= 1'b1;
                                end
                        end
                end else if (clear_row) begin
                        // everything above scan_row drops one row
                        for (int r = 1; r < board_rows_n; r++) begin
                                if (row_idx_t'(r) <= scan_row) begin
                                        grid[r] <= grid[r-1];
                                end
                        end
                        grid[0]       <= '0;
                        lines_cleared <= lines_cleared + 1'b1;
                end
        end

        assign row_full = &grid[scan_row];

endmodule

/* logic/column_tops.sv */
`timescale 1ns/1ns

module column_tops (
        input  tetris_pkg::row_t [tetris_pkg::board_rows_n-1:0] grid,
        output tetris_pkg::col_tops_t col_tops
);
        import tetris_pkg::*;

        // empty column behaves as if row board_rows_n were occupied
        localparam coord_t empty_top = coord_t'((board_rows_n - 1) * cell_px);

        always_comb begin
                for (int c = 0; c < board_cols; c++) begin
                        col_tops[c] = empty_top;
                        // bottom to top, so the highest hit wins
                        for (int r = board_rows_n - 1; r >= 0; r--) begin
                                if (grid[r][c]) begin
                                        col_tops[c] = coord_t'(r * cell_px - cell_px);
                                end
                        end
                end
        end

endmodule

/* logic/playfield_top.sv */
`timescale 1ns/1ns

module playfield_top (
        input  logic Clk,
        input  logic arst_n,
        input  logic at_bottom,
        input  tetris_pkg::coord_t square1x,
        input  tetris_pkg::coord_t square1y,
        input  tetris_pkg::coord_t square2x,
        input  tetris_pkg::coord_t square2y,
        input  tetris_pkg::coord_t square3x,
        input  tetris_pkg::coord_t square3y,
        input  tetris_pkg::coord_t square4x,
        input  tetris_pkg::coord_t square4y,
        output logic busy,
        output tetris_pkg::col_tops_t col_tops,
        output tetris_pkg::lines_t lines_cleared
);
        import tetris_pkg::*;

        logic place;
        logic clear_row;
        logic cnt_load;
        logic cnt_step;
        logic scan_last;
        logic row_full;
        row_idx_t scan_row;
        row_t [board_rows_n-1:0] grid;

        ////////////////////////////////////////////////////////////////////
        // sequencing
        ////////////////////////////////////////////////////////////////////

        lock_fsm u_lock_fsm (
                .Clk       (Clk),
                .arst_n    (arst_n),
                .at_bottom (at_bottom),
                .row_full  (row_full),
                .scan_last (scan_last),
                .busy      (busy),
                .place     (place),
                .clear_row (clear_row),
                .cnt_load  (cnt_load),
                .cnt_step  (cnt_step)
        );

        row_scan_counter u_row_scan_counter (
                .Clk       (Clk),
                .arst_n    (arst_n),
                .cnt_load  (cnt_load),
                .cnt_step  (cnt_step),
                .scan_row  (scan_row),
                .scan_last (scan_last)
        );

        ////////////////////////////////////////////////////////////////////
        // storage and heights
        ////////////////////////////////////////////////////////////////////

        board_rows u_board_rows (
                .Clk           (Clk),
                .arst_n        (arst_n),
                .at_bottom     (at_bottom),
                .square1x      (square1x),
                .square1y      (square1y),
                .square2x      (square2x),
                .square2y      (square2y),
                .square3x      (square3x),
                .square3y      (square3y),
                .square4x      (square4x),
                .square4y      (square4y),
                .place         (place),
                .clear_row     (clear_row),
                .scan_row      (scan_row),
                .row_full      (row_full),
                .grid          (grid),
                .lines_cleared (lines_cleared)
        );

        column_tops u_column_tops (
                .grid     (grid),
                .col_tops (col_tops)    // combinational from grid
        );

endmodule

/* test/playfield_properties.sv */
`timescale 1ns/1ns

module playfield_properties (
        input logic Clk,
        input logic arst_n,
        input logic busy,
        input logic place,
        input logic clear_row,
        input logic cnt_step
);

        place_one_cycle: assert property (@(posedge Clk) disable iff (!arst_n)
                place |=> !place)
                else $error("place held for more than one cycle");

        // clear rescans the same row, so no step alongside
        no_clear_with_step: assert property (@(posedge Clk) disable iff (!arst_n)
                !(clear_row && cnt_step))
                else $error("clear_row and cnt_step high together");

        idle_after_reset: assert property (@(posedge Clk) $rose(arst_n) |-> !busy)
                else $error("busy high in the first cycle after reset");

endmodule

bind lock_fsm playfield_properties u_playfield_properties (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .busy      (busy),
        .place     (place),
        .clear_row (clear_row),
        .cnt_step  (cnt_step)
);

/* test/playfield_tb.sv */
`timescale 1ns/1ns

module playfield_tb;
        import tetris_pkg::*;

        logic Clk;
        logic arst_n;
        logic at_bottom;
        coord_t square1x, square1y, square2x, square2y;
        coord_t square3x, square3y, square4x, square4y;
        logic busy;
        col_tops_t col_tops;
        lines_t lines_cleared;

        int errors = 0;
        int errors_at_start;
        int tests_passed = 0;
        int tests_failed = 0;
        int seed = 32'he0e4;
        string test_name;
        int piece_x [4];
        int piece_y [4];
        bit model_grid [board_rows_n][board_cols];     // indexed [row][col] with row 0 on top
        int model_lines;

        playfield_top u_playfield_top (.*);

        initial begin
                Clk = 1'b0;
                forever #20 Clk = ~Clk;
        end

        task automatic check_value(string what, int expected, int actual);
                assert (expected == actual) else begin
                        $display("Mismatch %s %s: expected %0d, actual %0d",
                                 test_name, what, expected, actual);
                        errors++;
                end
        endtask

        task automatic set_piece(int x0, int y0, int x1, int y1,
                                 int x2, int y2, int x3, int y3);
                piece_x  = '{x0, x1, x2, x3};
                piece_y  = '{y0, y1, y2, y3};
                square1x = coord_t'(x0);
                square1y = coord_t'(y0);
                square2x = coord_t'(x1);
                square2y = coord_t'(y1);
                square3x = coord_t'(x2);
                square3y = coord_t'(y2);
                square4x = coord_t'(x3);
                square4y = coord_t'(y3);
        endtask

        task automatic apply_reset();
                arst_n    = 1'b0;
                at_bottom = 1'b0;
                foreach (model_grid[r, c]) model_grid[r][c] = 1'b0;
                model_lines = 0;
                repeat (16) @(posedge Clk);
                #2 arst_n = 1'b1;
        endtask

        ////////////////////////////////////////////////////////////////////
        // reference model
        ////////////////////////////////////////////////////////////////////

        function automatic int expected_top(int c);
                for (int r = 0; r < board_rows_n; r++) begin
                        if (model_grid[r][c]) begin
                                return (r * cell_px - cell_px + 1024) % 1024;   // 10-bit wrap
                        end
                end
                return 380;
        endfunction

        // writes the piece, clears full rows, returns lines removed
        function automatic int model_lock();
                int cleared = 0;
                int r = board_rows_n - 1;
                bit full;
                for (int k = 0; k < 4; k++) begin
                        if (piece_x[k] < board_cols * cell_px &&
                            piece_y[k] < board_rows_n * cell_px) begin
                                model_grid[piece_y[k] / cell_px][piece_x[k] / cell_px] = 1'b1;
                        end
                end
                while (r >= 0) begin
                        full = 1'b1;
                        for (int c = 0; c < board_cols; c++) full &= model_grid[r][c];
                        if (full) begin
                                for (int rr = r; rr > 0; rr--) model_grid[rr] = model_grid[rr-1];
                                for (int c = 0; c < board_cols; c++) model_grid[0][c] = 1'b0;
                                cleared++;
                        end else begin
                                r--;
                        end
                end
                model_lines += cleared;
                return cleared;
        endfunction

        task automatic compare_outputs();
                for (int c = 0; c < board_cols; c++) begin
                        check_value($sformatf("col_tops[%0d]", c), expected_top(c),
                                    int'(col_tops[c]));
                end
                check_value("lines_cleared", model_lines % 256, int'(lines_cleared));
        endtask

        // pulses at_bottom with the current piece, waits for busy to fall
        task automatic lock_piece(int stray_at);
                int cycles = 0;
                int cleared;
                at_bottom = 1'b1;
                @(posedge Clk);
                #2 at_bottom = 1'b0;
                cleared = model_lock();
                assert (busy) else begin
                        $display("%s: busy did not rise after at_bottom", test_name);
                        errors++;
                end
                while (busy && cycles < 100) begin
                        cycles++;
                        if (cycles == stray_at) begin
                                set_piece(160, 0, 180, 0, 160, 20, 180, 20);
                                at_bottom = 1'b1;
                        end
                        @(posedge Clk);
                        #2 at_bottom = 1'b0;
                end
                if (busy) begin
                        $display("%s: timeout, busy still high after 100 cycles", test_name);
                        errors++;
                end else begin
                        // a clear costs its full-row scan plus the clear cycle
                        check_value("busy cycles", 21 + 2 * cleared, cycles);
                end
                compare_outputs();
        endtask

        task automatic start_test(string name);
                test_name       = name;
                errors_at_start = errors;
        endtask

        task automatic finish_test();
                if (errors == errors_at_start) begin
                        tests_passed++;
                        $display("%s: pass", test_name);
                end else begin
                        tests_failed++;
                        $display("%s: fail, %0d errors", test_name, errors - errors_at_start);
                end
        endtask

        ////////////////////////////////////////////////////////////////////
        // directed tests
        ////////////////////////////////////////////////////////////////////

        task automatic reset_test();
                start_test("reset");
                apply_reset();
                check_value("busy", 0, int'(busy));
                compare_outputs();
                finish_test();
        endtask

        task automatic place_test();
                start_test("place");
                set_piece(0, 360, 20, 360, 0, 380, 20, 380);    // square, bottom left
                lock_piece(-1);
                check_value("col_tops[0]", 340, int'(col_tops[0]));
                check_value("col_tops[1]", 340, int'(col_tops[1]));
                finish_test();
        endtask

        task automatic clear_test();
                int lines_before = model_lines;
                start_test("clear");
                set_piece(40, 380, 60, 380, 80, 380, 100, 380);
                lock_piece(-1);
                set_piece(120, 380, 140, 380, 160, 380, 180, 380);   // completes row 19
                lock_piece(-1);
                check_value("lines gained", lines_before + 1, int'(lines_cleared));
                check_value("col_tops[0]", 360, int'(col_tops[0]));
                finish_test();
        endtask

        task automatic multi_clear_test();
                int lines_before;
                start_test("multi_clear");
                apply_reset();
                set_piece(0, 280, 0, 300, 0, 320, 0, 340);      // col 0, rows 14 to 17
                lock_piece(-1);
                for (int x = 0; x < 160; x += 40) begin
                        set_piece(x, 360, x + 20, 360, x, 380, x + 20, 380);
                        lock_piece(-1);
                end
                lines_before = model_lines;
                set_piece(160, 360, 180, 360, 160, 380, 180, 380);
                lock_piece(-1);
                check_value("lines gained", lines_before + 2, int'(lines_cleared));
                check_value("col_tops[0]", 300, int'(col_tops[0]));
                finish_test();
        endtask

        task automatic ignored_input_test();
                start_test("ignored_input");
                set_piece(200, 0, 0, 640, 1000, 1000, 60, 100); // only col 3 row 5 on board
                lock_piece(-1);
                check_value("col_tops[3]", 80, int'(col_tops[3]));
                set_piece(80, 200, 100, 200, 80, 220, 100, 220);
                lock_piece(5);
                check_value("col_tops[9]", 380, int'(col_tops[9]));
                @(posedge Clk);
                #2;
                check_value("busy after stray pulse", 0, int'(busy));
                finish_test();
        endtask

        task automatic random_lock_test();
                int c;
                int bottom;
                start_test("random_locks");
                repeat (16) begin
                        c      = int'($unsigned($random(seed)) % board_cols);
                        bottom = board_rows_n - 1;
                        for (int r = board_rows_n - 1; r >= 0; r--) begin
                                if (model_grid[r][c]) bottom = r - 1;
                        end
                        if (bottom < 3) bottom = board_rows_n - 1;      // column almost full
                        set_piece(c * cell_px, bottom * cell_px,
                                  c * cell_px, (bottom - 1) * cell_px,
                                  c * cell_px, (bottom - 2) * cell_px,
                                  c * cell_px, (bottom - 3) * cell_px);
                        lock_piece(-1);
                end
                finish_test();
        endtask

        initial begin
                arst_n    = 1'b0;
                at_bottom = 1'b0;
                set_piece(0, 0, 0, 0, 0, 0, 0, 0);
                reset_test();
                place_test();
                clear_test();
                multi_clear_test();
                ignored_input_test();
                random_lock_test();
                $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
                if (errors == 0) begin
                        $display("Test OK");
                end else begin
                        $display("Test FAILED");
                end
                $finish;
        end

endmodule

/* compile.f */
logic/tetris_pkg.sv
logic/lock_fsm.sv
logic/row_scan_counter.sv
logic/board_rows.sv
logic/column_tops.sv
logic/playfield_top.sv
test/playfield_properties.sv
test/playfield_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= playfield_tb
FILELIST  ?= compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir
